/* src/fib_pkg.sv */
// Package with FIB table geometry, entry field widths, APB map, control fields and lookup states
package fib_pkg;

    // Name prefix and route fields
    localparam int PREFIX_W = 64;
    localparam int LEN_W    = 6;
    localparam int FACE_W   = 4;

    // Direct-mapped table geometry
    localparam int IDX_W       = 8;
    localparam int TABLE_DEPTH = 256;
    // Valid, length, masked prefix, face
    localparam int ENTRY_W     = 1 + LEN_W + PREFIX_W + FACE_W;
    // Entry count reaches TABLE_DEPTH, so one extra bit
    localparam int COUNT_W     = IDX_W + 1;

    // APB bus widths
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // Register offsets
    localparam logic [APB_AW-1:0] ADDR_PREFIX_LO = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_PREFIX_HI = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_CTRL      = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_STATUS    = 8'h0C;

    // CTRL register layout
    localparam int              OP_W          = 2;
    localparam logic [OP_W-1:0] OP_INSERT     = 2'd1;
    localparam logic [OP_W-1:0] OP_DELETE     = 2'd2;
    localparam int              CTRL_LEN_LSB  = 0;
    localparam int              CTRL_FACE_LSB = 8;
    localparam int              CTRL_OP_LSB   = 16;

    // STATUS register layout, count sits in the low bits
    localparam int STATUS_BUSY_BIT = 16;

    // Lookup FSM encoding
    localparam logic [1:0] LK_IDLE    = 2'd0;
    localparam logic [1:0] LK_REQUEST = 2'd1;
    localparam logic [1:0] LK_COMPARE = 2'd2;
    localparam logic [1:0] LK_RESPOND = 2'd3;

endpackage

/* src/prefix_hash.sv */
// Prefix masking to a given length and XOR folding into a table index
module prefix_hash
    import fib_pkg::*;
(
    input  logic [PREFIX_W-1:0] prefix,
    input  logic [LEN_W-1:0]    len,
    output logic [PREFIX_W-1:0] masked,
    output logic [IDX_W-1:0]    idx
);

    logic [PREFIX_W-1:0] mask;
    logic [IDX_W-1:0]    fold;

    always_comb begin
        // Keep the top len bits only, length 0 gives an all-zero mask
        mask   = ~({PREFIX_W{1'b1}} >> len);
        masked = prefix & mask;

        // XOR of all bytes of the masked prefix
        fold = '0;
        for (int b = 0; b < PREFIX_W / IDX_W; b++) begin
            fold = fold ^ masked[b*IDX_W +: IDX_W];
        end

        // Mix the length into the low bits
        // so that nested prefixes land in different slots
        idx = fold ^ {{(IDX_W - LEN_W){1'b0}}, len};
    end

endmodule

/* src/fib_table.sv */
// Single-port route memory with a swept valid-bit array and a valid entry counter
module fib_table
    import fib_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic                we,
    input  logic                wr_valid,
    input  logic [IDX_W-1:0]    idx,
    input  logic [LEN_W-1:0]    wr_len,
    input  logic [PREFIX_W-1:0] wr_prefix,
    input  logic [FACE_W-1:0]   wr_face,
    output logic                rd_valid,
    output logic [LEN_W-1:0]    rd_len,
    output logic [PREFIX_W-1:0] rd_prefix,
    output logic [FACE_W-1:0]   rd_face,
    output logic [COUNT_W-1:0]  entry_count
);

    // Payload word holds length, prefix and face
    logic [ENTRY_W-2:0]     mem [TABLE_DEPTH];
    logic [ENTRY_W-2:0]     rd_word;
    logic [TABLE_DEPTH-1:0] vbits;

    // Post-reset clear sweep
    logic                   sweeping;
    logic [IDX_W-1:0]       clr_idx;
    logic                   slot_live;

    // Slots the sweep has not reached yet read as empty
    assign slot_live = vbits[idx] & (~sweeping | (idx < clr_idx));

    // Entry storage, read data one cycle after en
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[idx] <= {wr_len, wr_prefix, wr_face};
            end else begin
                rd_word <= mem[idx];
            end
        end
    end

    assign {rd_len, rd_prefix, rd_face} = rd_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping    <= 1'b1;
            clr_idx     <= '0;
            entry_count <= '0;
            rd_valid    <= 1'b0;
        end else begin
            // One slot cleared per cycle
            if (sweeping) begin
                vbits[clr_idx] <= 1'b0;
                clr_idx        <= clr_idx + 1'b1;
                if (clr_idx == IDX_W'(TABLE_DEPTH - 1)) begin
                    sweeping <= 1'b0;
                end
            end
            // Table write wins over the sweep on the same slot
            if (en && we) begin
                vbits[idx] <= wr_valid;
                if (wr_valid && !slot_live) begin
                    entry_count <= entry_count + 1'b1;
                end else if (!wr_valid && slot_live) begin
                    entry_count <= entry_count - 1'b1;
                end
            end
            rd_valid <= en & ~we & slot_live;
        end
    end

endmodule

/* src/fib_arbiter.sv */
// Fixed-priority table arbiter with hash and table port steering
module fib_arbiter
    import fib_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // Configuration peer
    input  logic                cfg_req,
    input  logic                cfg_we,
    input  logic                cfg_valid,
    input  logic [PREFIX_W-1:0] cfg_prefix,
    input  logic [LEN_W-1:0]    cfg_len,
    input  logic [FACE_W-1:0]   cfg_face,
    output logic                cfg_gnt,
    // Lookup peer
    input  logic                lk_req,
    input  logic [PREFIX_W-1:0] lk_prefix,
    input  logic [LEN_W-1:0]    lk_len,
    output logic                lk_gnt,
    // Shared hash and table port
    output logic [PREFIX_W-1:0] hash_prefix,
    output logic [LEN_W-1:0]    hash_len,
    output logic                tbl_en,
    output logic                tbl_we,
    output logic                tbl_wr_valid,
    output logic [FACE_W-1:0]   tbl_wr_face
);

    // High in the cycle after any grant
    logic block;

    // Configuration first, lookup only when config is quiet
    assign cfg_gnt = cfg_req & ~block;
    assign lk_gnt  = lk_req & ~cfg_req & ~block;

    always_ff @(posedge clk) begin
        if (rst) begin
            block <= 1'b0;
        end else begin
            block <= cfg_gnt | lk_gnt;
        end
    end

    // Lookup fields by default
    // so the hash still shows them during its compare cycle
    assign hash_prefix = cfg_gnt ? cfg_prefix : lk_prefix;
    assign hash_len    = cfg_gnt ? cfg_len : lk_len;

    assign tbl_en       = cfg_gnt | lk_gnt;
    assign tbl_we       = cfg_gnt & cfg_we;
    assign tbl_wr_valid = cfg_valid;
    assign tbl_wr_face  = cfg_face;

endmodule

/* src/fib_lookup.sv */
// Longest-prefix-match FSM walking the prefix length downward one table read per step
module fib_lookup
    import fib_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // Request side
    input  logic                lookup_valid,
    input  logic [PREFIX_W-1:0] lookup_prefix,
    input  logic [LEN_W-1:0]    lookup_len,
    output logic                lookup_ready,
    // Response side
    output logic                resp_valid,
    output logic                resp_hit,
    output logic [FACE_W-1:0]   resp_face,
    output logic [LEN_W-1:0]    resp_len,
    input  logic                resp_ready,
    // Arbiter
    output logic                lk_req,
    input  logic                lk_gnt,
    output logic [PREFIX_W-1:0] lk_prefix,
    output logic [LEN_W-1:0]    lk_len,
    // Hash and table read data
    input  logic [PREFIX_W-1:0] masked,
    input  logic                rd_valid,
    input  logic [LEN_W-1:0]    rd_len,
    input  logic [PREFIX_W-1:0] rd_prefix,
    input  logic [FACE_W-1:0]   rd_face
);

    logic [1:0]          state;
    logic [PREFIX_W-1:0] prefix_q;
    logic [LEN_W-1:0]    len_q;
    logic                hit;

    // Closed while reset is held
    assign lookup_ready = (state == LK_IDLE) && !rst;
    assign resp_valid   = (state == LK_RESPOND);
    assign lk_req       = (state == LK_REQUEST);
    assign lk_prefix    = prefix_q;
    assign lk_len       = len_q;

    // Slot must hold exactly this length and masked name
    assign hit = rd_valid && (rd_len == len_q) && (rd_prefix == masked);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LK_IDLE;
        end else begin
            case (state)
                LK_IDLE: begin
                    if (lookup_valid) begin
                        state <= LK_REQUEST;
                    end
                end
                LK_REQUEST: begin
                    // Wait out config traffic
                    if (lk_gnt) begin
                        state <= LK_COMPARE;
                    end
                end
                LK_COMPARE: begin
                    // Length 0 is the last try
                    if (hit || len_q == '0) begin
                        state <= LK_RESPOND;
                    end else begin
                        state <= LK_REQUEST;
                    end
                end
                default: begin
                    // Result held until taken
                    if (resp_ready) begin
                        state <= LK_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid && lookup_ready) begin
            prefix_q <= lookup_prefix;
            len_q    <= lookup_len;
        end else if (state == LK_COMPARE && !hit && len_q != '0) begin
            len_q <= len_q - 1'b1;
        end
        // Result capture
        if (state == LK_COMPARE) begin
            resp_hit  <= hit;
            resp_face <= hit ? rd_face : '0;
            resp_len  <= len_q;
        end
    end

endmodule

/* src/fib_config.sv */
// APB slave with prefix, control and status registers issuing route insert and delete
module fib_config
    import fib_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // APB
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [APB_AW-1:0]   paddr,
    input  logic [APB_DW-1:0]   pwdata,
    output logic [APB_DW-1:0]   prdata,
    output logic                pready,
    // Table request
    output logic                cfg_req,
    output logic                cfg_we,
    output logic                cfg_valid,
    output logic [PREFIX_W-1:0] cfg_prefix,
    output logic [LEN_W-1:0]    cfg_len,
    output logic [FACE_W-1:0]   cfg_face,
    input  logic                cfg_gnt,
    input  logic [COUNT_W-1:0]  entry_count
);

    logic [APB_DW-1:0] prefix_lo;
    logic [APB_DW-1:0] prefix_hi;
    logic [LEN_W-1:0]  len_q;
    logic [FACE_W-1:0] face_q;
    logic              valid_q;
    // Request pending, and granted but not yet completed on the bus
    logic              req_q;
    logic              done_q;
    logic              access;
    logic              ctrl_wr;
    logic [OP_W-1:0]   op;
    logic              op_ok;

    assign access  = psel & penable;
    assign ctrl_wr = access & pwrite & (paddr == ADDR_CTRL);
    assign op      = pwdata[CTRL_OP_LSB +: OP_W];
    assign op_ok   = (op == OP_INSERT) || (op == OP_DELETE);

    // Unknown ops complete at once, real ones wait for the grant
    assign pready = access & (~ctrl_wr | ~op_ok | done_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            prefix_lo <= '0;
            prefix_hi <= '0;
            len_q     <= '0;
            face_q    <= '0;
            valid_q   <= 1'b0;
            req_q     <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            if (access && pwrite && paddr == ADDR_PREFIX_LO) begin
                prefix_lo <= pwdata;
            end
            if (access && pwrite && paddr == ADDR_PREFIX_HI) begin
                prefix_hi <= pwdata;
            end
            // Capture fields once per CTRL transfer
            if (ctrl_wr && op_ok && !req_q && !done_q) begin
                req_q   <= 1'b1;
                len_q   <= pwdata[CTRL_LEN_LSB +: LEN_W];
                face_q  <= pwdata[CTRL_FACE_LSB +: FACE_W];
                valid_q <= (op == OP_INSERT);
            end else if (req_q && cfg_gnt) begin
                req_q  <= 1'b0;
                done_q <= 1'b1;
            end else if (done_q && access) begin
                done_q <= 1'b0;
            end
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                ADDR_PREFIX_LO: prdata = prefix_lo;
                ADDR_PREFIX_HI: prdata = prefix_hi;
                ADDR_CTRL: begin
                    prdata[CTRL_LEN_LSB +: LEN_W]   = len_q;
                    prdata[CTRL_FACE_LSB +: FACE_W] = face_q;
                end
                ADDR_STATUS: begin
                    prdata[COUNT_W-1:0]     = entry_count;
                    prdata[STATUS_BUSY_BIT] = req_q;
                end
                default: prdata = '0;
            endcase
        end
    end

    // Configuration only ever writes the table
    assign cfg_req    = req_q;
    assign cfg_we     = 1'b1;
    assign cfg_valid  = valid_q;
    assign cfg_prefix = {prefix_hi, prefix_lo};
    assign cfg_len    = len_q;
    assign cfg_face   = face_q;

endmodule

/* src/fib_top.sv */
// FIB top level wiring lookup, configuration, arbiter, hash and table
module fib_top
    import fib_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                lookup_valid,
    input  logic [PREFIX_W-1:0] lookup_prefix,
    input  logic [LEN_W-1:0]    lookup_len,
    output logic                lookup_ready,
    output logic                resp_valid,
    output logic                resp_hit,
    output logic [FACE_W-1:0]   resp_face,
    output logic [LEN_W-1:0]    resp_len,
    input  logic                resp_ready,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [APB_AW-1:0]   paddr,
    input  logic [APB_DW-1:0]   pwdata,
    output logic [APB_DW-1:0]   prdata,
    output logic                pready
);

    // Config to arbiter
    logic                cfg_req, cfg_we, cfg_valid, cfg_gnt;
    logic [PREFIX_W-1:0] cfg_prefix;
    logic [LEN_W-1:0]    cfg_len;
    logic [FACE_W-1:0]   cfg_face;
    // Lookup to arbiter
    logic                lk_req, lk_gnt;
    logic [PREFIX_W-1:0] lk_prefix;
    logic [LEN_W-1:0]    lk_len;
    // Shared port
    logic [PREFIX_W-1:0] hash_prefix, masked, rd_prefix;
    logic [LEN_W-1:0]    hash_len, rd_len;
    logic [IDX_W-1:0]    idx;
    logic                tbl_en, tbl_we, tbl_wr_valid, rd_valid;
    logic [FACE_W-1:0]   tbl_wr_face, rd_face;
    logic [COUNT_W-1:0]  entry_count;

    fib_lookup u_lookup (
        .clk, .rst, .lookup_valid, .lookup_prefix, .lookup_len, .lookup_ready,
        .resp_valid, .resp_hit, .resp_face, .resp_len, .resp_ready,
        .lk_req, .lk_gnt, .lk_prefix, .lk_len,
        .masked, .rd_valid, .rd_len, .rd_prefix, .rd_face
    );

    fib_config u_config (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .cfg_req, .cfg_we, .cfg_valid, .cfg_prefix, .cfg_len, .cfg_face,
        .cfg_gnt, .entry_count
    );

    fib_arbiter u_arbiter (
        .clk, .rst,
        .cfg_req, .cfg_we, .cfg_valid, .cfg_prefix, .cfg_len, .cfg_face, .cfg_gnt,
        .lk_req, .lk_prefix, .lk_len, .lk_gnt,
        .hash_prefix, .hash_len, .tbl_en, .tbl_we, .tbl_wr_valid, .tbl_wr_face
    );

    prefix_hash u_hash (
        .prefix (hash_prefix),
        .len    (hash_len),
        .masked (masked),
        .idx    (idx)
    );

    // Written entries carry the masked prefix and granted length
    fib_table u_table (
        .clk, .rst,
        .en       (tbl_en),
        .we       (tbl_we),
        .wr_valid (tbl_wr_valid),
        .idx      (idx),
        .wr_len   (hash_len),
        .wr_prefix(masked),
        .wr_face  (tbl_wr_face),
        .rd_valid, .rd_len, .rd_prefix, .rd_face, .entry_count
    );

endmodule

/* tests/tb_fib.sv */
// Directed FIB testbench with a slot-level route model, APB and lookup tasks, and a value checker
module tb_fib
    import fib_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // About 20 lookups of up to 130 cycles each, the 256-cycle clear and APB traffic,
    // with a wide margin on top
    localparam int MAX_CYCLES = 20000;

    logic                clk;
    logic                rst;
    logic                lookup_valid;
    logic [PREFIX_W-1:0] lookup_prefix;
    logic [LEN_W-1:0]    lookup_len;
    logic                lookup_ready;
    logic                resp_valid;
    logic                resp_hit;
    logic [FACE_W-1:0]   resp_face;
    logic [LEN_W-1:0]    resp_len;
    logic                resp_ready;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [APB_AW-1:0]   paddr;
    logic [APB_DW-1:0]   pwdata;
    logic [APB_DW-1:0]   prdata;
    logic                pready;

    // Route model, one entry per table slot
    bit                  m_valid  [TABLE_DEPTH];
    int                  m_len    [TABLE_DEPTH];
    logic [PREFIX_W-1:0] m_prefix [TABLE_DEPTH];
    logic [FACE_W-1:0]   m_face   [TABLE_DEPTH];

    int                  errors;
    int                  checks;
    int                  cycles;
    logic [PREFIX_W-1:0] route_base;

    // Snapshot of a held response
    bit                  hold_active;
    logic                snap_hit;
    logic [FACE_W-1:0]   snap_face;
    logic [LEN_W-1:0]    snap_len;

    fib_top u_fib_top (
        .clk, .rst, .lookup_valid, .lookup_prefix, .lookup_len, .lookup_ready,
        .resp_valid, .resp_hit, .resp_face, .resp_len, .resp_ready,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Response must not move while held
    always @(negedge clk) begin
        if (hold_active) begin
            compare("resp_valid", resp_valid, 1'b1);
            compare("lookup_ready", lookup_ready, 1'b0);
            compare("resp_hit", resp_hit, snap_hit);
            compare("resp_face", resp_face, snap_face);
            compare("resp_len", resp_len, snap_len);
        end
    end

    // Top len bits survive
    function automatic logic [63:0] mask_prefix(input logic [63:0] p, input int len);
        logic [63:0] m;
        for (int i = 0; i < 64; i++) begin
            m[i] = (i >= 64 - len);
        end
        return p & m;
    endfunction

    // Byte fold of the masked name, then length into the low bits
    function automatic logic [7:0] slot_of(input logic [63:0] p, input int len);
        logic [63:0] mp;
        logic [7:0]  f;
        mp = mask_prefix(p, len);
        f  = 8'h00;
        for (int b = 0; b < 8; b++) begin
            f = f ^ mp[8*b +: 8];
        end
        return f ^ 8'(len);
    endfunction

    function automatic int count_routes();
        int n;
        n = 0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            n += m_valid[i];
        end
        return n;
    endfunction

    // Walk lengths downward through the model
    task automatic model_lookup(input logic [63:0] p, input int len, output logic hit,
                                output logic [FACE_W-1:0] face, output logic [LEN_W-1:0] mlen);
        logic [7:0] s;
        hit  = 1'b0;
        face = '0;
        mlen = '0;
        for (int k = len; k >= 0; k--) begin
            s = slot_of(p, k);
            if (!hit && m_valid[s] && m_len[s] == k && m_prefix[s] == mask_prefix(p, k)) begin
                hit  = 1'b1;
                face = m_face[s];
                mlen = LEN_W'(k);
            end
        end
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output int stall);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        stall = 0;
        @(negedge clk);
        while (!pready) begin
            stall++;
            @(negedge clk);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Prefix words, then the CTRL write that starts the table update
    task automatic write_route(input logic [63:0] p, input int len, input logic [3:0] face,
                               input logic [OP_W-1:0] op);
        int stall;
        logic [APB_DW-1:0] ctrl;
        ctrl = '0;
        ctrl[CTRL_LEN_LSB +: LEN_W]   = LEN_W'(len);
        ctrl[CTRL_FACE_LSB +: FACE_W] = face;
        ctrl[CTRL_OP_LSB +: OP_W]     = op;
        apb_write(ADDR_PREFIX_LO, p[31:0], stall);
        apb_write(ADDR_PREFIX_HI, p[63:32], stall);
        apb_write(ADDR_CTRL, ctrl, stall);
        if (stall < 1 || stall > 3) begin
            errors++;
            $display("ERROR at %0t: CTRL write held pready low for %0d cycles", $time, stall);
        end
    endtask

    task automatic add_route(input logic [63:0] p, input int len, input logic [3:0] face);
        logic [7:0] s;
        write_route(p, len, face, OP_INSERT);
        s = slot_of(p, len);
        m_valid[s]  = 1'b1;
        m_len[s]    = len;
        m_prefix[s] = mask_prefix(p, len);
        m_face[s]   = face;
    endtask

    task automatic del_route(input logic [63:0] p, input int len);
        write_route(p, len, 4'h0, OP_DELETE);
        m_valid[slot_of(p, len)] = 1'b0;
    endtask

    task automatic check_status();
        logic [APB_DW-1:0] st;
        apb_read(ADDR_STATUS, st);
        compare("status.count", st[COUNT_W-1:0], count_routes());
        compare("status.busy", st[STATUS_BUSY_BIT], 1'b0);
    endtask

    // Request handshake, then wait for the result
    task automatic issue_lookup(input logic [63:0] p, input int len);
        @(posedge clk);
        lookup_valid  <= 1'b1;
        lookup_prefix <= p;
        lookup_len    <= LEN_W'(len);
        @(negedge clk);
        while (!lookup_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        lookup_valid <= 1'b0;
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic release_resp();
        @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk);
        resp_ready <= 1'b0;
    endtask

    task automatic check_result(input logic hit, input logic [3:0] face, input logic [5:0] len);
        compare("resp_hit", resp_hit, hit);
        compare("resp_len", resp_len, hit ? len : 6'd0);
        if (hit) begin
            compare("resp_face", resp_face, face);
        end
    endtask

    task automatic check_lookup(input logic [63:0] p, input int len);
        logic              hit;
        logic [FACE_W-1:0] face;
        logic [LEN_W-1:0]  mlen;
        model_lookup(p, len, hit, face, mlen);
        issue_lookup(p, len);
        check_result(hit, face, mlen);
        release_resp();
    endtask

    task automatic test_reset_state();
        check_lookup({$urandom, $urandom}, 63);
        check_lookup({$urandom, $urandom}, 5);
        check_status();
        // Valid bits clear one slot per cycle after reset
        repeat (TABLE_DEPTH + 16) @(posedge clk);
        check_lookup({$urandom, $urandom}, 40);
    endtask

    task automatic test_longest_match();
        route_base = {$urandom, $urandom};
        add_route(route_base, 8, 4'd1);
        add_route(route_base, 16, 4'd2);
        add_route(route_base, 28, 4'd3);
        add_route(route_base, 44, 4'd4);
        check_status();
        check_lookup(route_base, 63);
        // Differs below the 28-bit route
        check_lookup(route_base ^ (64'd1 << 30), 63);
        // Differs below the 8-bit route
        check_lookup(route_base ^ (64'd1 << 50), 63);
        check_lookup(route_base, 20);
        check_lookup(route_base ^ (64'd1 << 60), 63);
    endtask

    task automatic test_default_route();
        add_route(64'd0, 0, 4'd9);
        check_status();
        check_lookup(route_base ^ (64'd1 << 60), 63);
        check_lookup(~route_base, 63);
    endtask

    task automatic test_delete();
        del_route(route_base, 44);
        check_status();
        check_lookup(route_base, 63);
        del_route(route_base, 28);
        check_status();
        check_lookup(route_base, 63);
    endtask

    task automatic test_collision();
        logic [63:0] a;
        logic [63:0] b;
        a = {$urandom, $urandom};
        a[55:48] = a[63:56] ^ 8'h5a;
        // Swapping two top bytes keeps the byte fold
        b = {a[55:48], a[63:56], a[47:0]};
        add_route(a, 32, 4'd5);
        add_route(b, 32, 4'd6);
        check_status();
        check_lookup(a, 63);
        check_lookup(b, 63);
        check_lookup(b, 32);
    endtask

    task automatic test_backpressure();
        logic              hit;
        logic [FACE_W-1:0] face;
        logic [LEN_W-1:0]  mlen;
        int                stall;
        add_route(route_base, 36, 4'd7);
        model_lookup(route_base, 63, hit, face, mlen);
        issue_lookup(route_base, 63);
        snap_hit    = resp_hit;
        snap_face   = resp_face;
        snap_len    = resp_len;
        hold_active = 1'b1;
        // Config traffic while the result sits unclaimed
        apb_write(ADDR_PREFIX_LO, $urandom, stall);
        add_route({$urandom, $urandom}, 12, 4'd3);
        repeat (4) @(posedge clk);
        @(negedge clk);
        hold_active = 1'b0;
        check_result(hit, face, mlen);
        release_resp();
        check_status();
        check_lookup(route_base, 63);
    endtask

    initial begin
        void'($urandom(32'h965371e9));
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        hold_active   = 1'b0;
        rst           = 1'b1;
        lookup_valid  = 1'b0;
        lookup_prefix = '0;
        lookup_len    = '0;
        resp_ready    = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        // Both sides quiet while reset is held
        compare("lookup_ready", lookup_ready, 1'b0);
        compare("resp_valid", resp_valid, 1'b0);
        compare("pready", pready, 1'b0);
        @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_longest_match();
        test_default_route();
        test_delete();
        test_collision();
        test_backpressure();

        repeat (2) @(posedge clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* fib.f */
src/fib_pkg.sv
src/prefix_hash.sv
src/fib_table.sv
src/fib_arbiter.sv
src/fib_lookup.sv
src/fib_config.sv
src/fib_top.sv
tests/tb_fib.sv

/* Bender.yml */
package:
  name: fib

sources:
  - src/fib_pkg.sv
  - src/prefix_hash.sv
  - src/fib_table.sv
  - src/fib_arbiter.sv
  - src/fib_lookup.sv
  - src/fib_config.sv
  - src/fib_top.sv
  - target: test
    files:
      - tests/tb_fib.sv
